// File: rtl/alarmClockPkg.sv
`default_nettype none

package alarmClockPkg;

    typedef logic [3:0] bcdDigit_t;  // One decimal digit

    // Most significant digit first, so secOnes sits in bits 3:0
    typedef struct packed {
        bcdDigit_t minTens;
        bcdDigit_t minOnes;
        bcdDigit_t secTens;
        bcdDigit_t secOnes;
    } clockTime_t;

    // Digit view for the display, flat view for the alarm compare
    typedef union packed {
        clockTime_t  digits;
        logic [15:0] flat;
    } clockTime_u;

    // Laid out in board order, SW15 on the left
    typedef struct packed {
        bcdDigit_t  digitValue;   // SW15..SW12
        logic [3:0] saveDigit;    // SW11..SW8, bit 0 is secOnes
        logic       spare;        // SW7
        logic [3:0] liveDigit;    // SW6..SW3, bit 0 is secOnes
        logic       showAlarm;    // SW2
        logic       alarmEnable;  // SW1
        logic       clockRun;     // SW0, low holds 00:00
    } switches_t;

    // All fields active low
    typedef struct packed {
        logic [7:0] anodes;
        logic       dp;
        logic [6:0] segments;  // a in bit 6, g in bit 0
    } segDrive_t;

    // Active low patterns, abcdefg
    localparam logic [6:0] SEG_PATTERNS [0:9] = '{
        7'b0000001,  // 0
        7'b1001111,  // 1
        7'b0010010,  // 2
        7'b0000110,  // 3
        7'b1001100,  // 4
        7'b0100100,  // 5
        7'b0100000,  // 6
        7'b0001111,  // 7
        7'b0000000,  // 8
        7'b0000100   // 9
    };

    localparam int DIGIT_COUNT   = 4;
    localparam int ALARM_SECONDS = 10;  // Alarm window length in seconds

    // Board defaults for a 100 MHz clock
    localparam int DEFAULT_CLKS_PER_SECOND  = 100_000_000;
    localparam int DEFAULT_CLKS_PER_REFRESH = 125_000;      // 800 Hz scan, 200 Hz per digit
    localparam int DEFAULT_TONE_HALF_PERIOD = 113_636;      // About 440 Hz

endpackage

`default_nettype wire

// File: rtl/tickGenerator.sv
`timescale 1ns/1ps
`default_nettype none

module tickGenerator #(
    parameter int clksPerSecond  = 100_000_000,
    parameter int clksPerRefresh = 125_000
) (
    input  logic clk,
    input  logic reset,
    output logic secondTick,
    output logic refreshTick
);

    // Extra bit of width keeps a divide by one legal
    logic [$clog2(clksPerSecond + 1)-1:0]  secCount;
    logic [$clog2(clksPerRefresh + 1)-1:0] refreshCount;

    // Tick lands on the edge after the count hits N-1
    always_ff @(posedge clk) begin
        if (!reset) begin
            secCount   <= '0;
            secondTick <= 1'b0;
        end else if (secCount == clksPerSecond - 1) begin
            secCount   <= '0;
            secondTick <= 1'b1;
        end else begin
            secCount   <= secCount + 1'b1;
            secondTick <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            refreshCount <= '0;
            refreshTick  <= 1'b0;
        end else if (refreshCount == clksPerRefresh - 1) begin
            refreshCount <= '0;
            refreshTick  <= 1'b1;
        end else begin
            refreshCount <= refreshCount + 1'b1;
            refreshTick  <= 1'b0;
        end
    end

    // One cycle pulse, never back to back unless dividing by one
    secondTickSingle: assert property (@(posedge clk) disable iff (!reset)
        (clksPerSecond > 1 && secondTick) |=> !secondTick);

endmodule

`default_nettype wire

// File: rtl/timeCounter.sv
`timescale 1ns/1ps
`default_nettype none

module timeCounter (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      secondTick,
    input  logic                      clockRun,
    output alarmClockPkg::clockTime_t currentTime
);

    // Cascaded BCD, every carry resolves within the same tick
    always_ff @(posedge clk) begin
        if (!reset) begin
            currentTime <= '0;
        end else if (!clockRun) begin
            currentTime <= '0;  // Run switch off holds 00:00
        end else if (secondTick) begin
            if (currentTime.secOnes == 4'd9) begin
                currentTime.secOnes <= 4'd0;
                if (currentTime.secTens == 4'd5) begin
                    currentTime.secTens <= 4'd0;
                    // Minute boundary
                    if (currentTime.minOnes == 4'd9) begin
                        currentTime.minOnes <= 4'd0;
                        if (currentTime.minTens == 4'd5) begin
                            currentTime.minTens <= 4'd0;  // 59:59 wraps to 00:00
                        end else begin
                            currentTime.minTens <= currentTime.minTens + 4'd1;
                        end
                    end else begin
                        currentTime.minOnes <= currentTime.minOnes + 4'd1;
                    end
                end else begin
                    currentTime.secTens <= currentTime.secTens + 4'd1;
                end
            end else begin
                currentTime.secOnes <= currentTime.secOnes + 4'd1;
            end
        end
    end

    // Tens digits never pass 5, ones never pass 9
    digitsInRange: assert property (@(posedge clk) disable iff (!reset)
        currentTime.secOnes <= 4'd9 && currentTime.secTens <= 4'd5 &&
        currentTime.minOnes <= 4'd9 && currentTime.minTens <= 4'd5);

endmodule

`default_nettype wire

// File: rtl/alarmSetter.sv
`timescale 1ns/1ps
`default_nettype none

module alarmSetter (
    input  logic                      clk,
    input  logic                      reset,
    input  logic [3:0]                saveDigit,
    input  alarmClockPkg::bcdDigit_t  digitValue,
    output alarmClockPkg::clockTime_t savedAlarm
);

    logic [3:0] savePrev;  // Save switches as of last cycle
    logic [3:0] saveRise;

    // Cleared at reset so a switch already up counts as a press
    assign saveRise = saveDigit & ~savePrev;

    always_ff @(posedge clk) begin
        if (!reset) begin
            savePrev <= '0;
        end else begin
            savePrev <= saveDigit;
        end
    end

    // Bit i of saveDigit owns digit i with secOnes first
    always_ff @(posedge clk) begin
        if (!reset) begin
            savedAlarm <= '0;  // Alarm starts at 00:00
        end else begin
            for (int i = 0; i < 4; i++) begin
                if (saveRise[i]) begin
                    savedAlarm[i*4 +: 4] <= digitValue;  // Several may load at once
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/alarmController.sv
`timescale 1ns/1ps
`default_nettype none

module alarmController #(
    parameter int toneHalfPeriod = 113_636
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      secondTick,
    input  logic                      alarmEnable,
    input  alarmClockPkg::clockTime_t currentTime,
    input  alarmClockPkg::clockTime_t savedAlarm,
    output logic                      alarmLed,
    output logic                      alarmActive,
    output logic                      beep
);

    alarmClockPkg::clockTime_u nowView;
    alarmClockPkg::clockTime_u alarmView;
    logic alarmMatch;
    logic windowClosing;
    logic [$clog2(alarmClockPkg::ALARM_SECONDS)-1:0] windowCount;  // Ticks seen so far
    logic [$clog2(toneHalfPeriod + 1)-1:0]           toneCount;

    assign nowView.digits   = currentTime;
    assign alarmView.digits = savedAlarm;
    assign alarmMatch       = alarmEnable && (nowView.flat == alarmView.flat);  // Whole word

    // Last tick of the window
    assign windowClosing = secondTick && alarmActive &&
                           (windowCount == alarmClockPkg::ALARM_SECONDS - 1);

    always_ff @(posedge clk) begin
        if (!reset) begin
            alarmLed <= 1'b0;
        end else begin
            alarmLed <= alarmEnable;
        end
    end

    // Opening tick counts as the first second
    always_ff @(posedge clk) begin
        if (!reset) begin
            alarmActive <= 1'b0;
            windowCount <= '0;
        end else if (windowClosing) begin
            alarmActive <= 1'b0;
            windowCount <= '0;
        end else if (secondTick && (alarmActive || alarmMatch)) begin
            alarmActive <= 1'b1;  // Match inside an open window changes nothing
            windowCount <= windowCount + 1'b1;
        end
    end

    // Square wave, low at the start of the window
    always_ff @(posedge clk) begin
        if (!reset || !alarmActive || windowClosing) begin
            toneCount <= '0;
            beep      <= 1'b0;  // Drops together with alarmActive
        end else if (toneCount == toneHalfPeriod - 1) begin
            toneCount <= '0;
            beep      <= ~beep;
        end else begin
            toneCount <= toneCount + 1'b1;
        end
    end

    beepOnlyInWindow: assert property (@(posedge clk) !alarmActive |-> !beep);

    // Opening tick plus nine more, then closed
    windowLength: assert property (@(posedge clk) disable iff (!reset)
        $rose(alarmActive) |->
            (alarmActive throughout secondTick [-> alarmClockPkg::ALARM_SECONDS - 1])
            ##1 !alarmActive);

endmodule

`default_nettype wire

// File: rtl/displayScanner.sv
`timescale 1ns/1ps
`default_nettype none

module displayScanner (
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic                                   refreshTick,
    input  logic                                   showAlarm,
    input  logic [alarmClockPkg::DIGIT_COUNT-1:0]  liveDigit,
    input  alarmClockPkg::bcdDigit_t               digitValue,
    input  alarmClockPkg::clockTime_t              currentTime,
    input  alarmClockPkg::clockTime_t              savedAlarm,
    output alarmClockPkg::segDrive_t               display
);

    // 0 secOnes, 1 secTens, 2 minOnes, 3 minTens
    logic [$clog2(alarmClockPkg::DIGIT_COUNT)-1:0] scanPos;
    logic [$clog2(alarmClockPkg::DIGIT_COUNT)-1:0] nextPos;

    alarmClockPkg::bcdDigit_t timeDigit;
    alarmClockPkg::bcdDigit_t alarmDigit;
    alarmClockPkg::bcdDigit_t shownDigit;
    alarmClockPkg::segDrive_t nextDrive;

    assign nextPos = scanPos + 1'b1;  // Power of two positions, wraps on its own

    // Everything is decoded for the position about to be shown
    always_comb begin
        timeDigit  = currentTime[{nextPos, 2'b00} +: 4];
        alarmDigit = savedAlarm[{nextPos, 2'b00} +: 4];
        if (liveDigit[nextPos]) begin
            alarmDigit = digitValue;  // Live switches while dialing in
        end
        shownDigit = showAlarm ? alarmDigit : timeDigit;

        if (shownDigit > 4'd9) begin
            nextDrive.segments = alarmClockPkg::SEG_PATTERNS[0];  // Out of range shows 0
        end else begin
            nextDrive.segments = alarmClockPkg::SEG_PATTERNS[shownDigit];
        end

        // Time on the right four digits, alarm on the left four
        nextDrive.anodes = ~(8'b0000_0001 << {showAlarm, nextPos});
        nextDrive.dp     = (nextPos != 2'd2);  // Point after the minutes
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            scanPos <= '1;  // Last position, first refresh lands on 0
        end else if (refreshTick) begin
            scanPos <= nextPos;
        end
    end

    // Segments, point and anode move together
    always_ff @(posedge clk) begin
        if (!reset) begin
            display <= '1;  // Blank
        end else if (refreshTick) begin
            display <= nextDrive;
        end
    end

    // Once scanning starts the display is never blank or doubled
    oneAnodeLit: assert property (@(posedge clk) disable iff (!reset)
        (refreshTick || $onehot(~display.anodes)) |=> $onehot(~display.anodes));

endmodule

`default_nettype wire

// File: rtl/alarmClockTop.sv
`timescale 1ns/1ps
`default_nettype none

module alarmClockTop #(
    parameter int clksPerSecond  = alarmClockPkg::DEFAULT_CLKS_PER_SECOND,
    parameter int clksPerRefresh = alarmClockPkg::DEFAULT_CLKS_PER_REFRESH,
    parameter int toneHalfPeriod = alarmClockPkg::DEFAULT_TONE_HALF_PERIOD
) (
    input  logic                     clk,
    input  logic                     reset,
    input  alarmClockPkg::switches_t switches,
    output alarmClockPkg::segDrive_t display,
    output logic                     alarmLed,
    output logic                     alarmActive,
    output logic                     beep
);

    logic secondTick;   // 1 Hz enable
    logic refreshTick;  // Scan enable
    alarmClockPkg::clockTime_t currentTime;
    alarmClockPkg::clockTime_t savedAlarm;

    tickGenerator #(.clksPerSecond(clksPerSecond), .clksPerRefresh(clksPerRefresh)) u_tickGenerator (
        .clk(clk), .reset(reset), .secondTick(secondTick), .refreshTick(refreshTick));

    timeCounter u_timeCounter (
        .clk(clk), .reset(reset), .secondTick(secondTick),
        .clockRun(switches.clockRun), .currentTime(currentTime));

    alarmSetter u_alarmSetter (
        .clk(clk), .reset(reset), .saveDigit(switches.saveDigit),
        .digitValue(switches.digitValue), .savedAlarm(savedAlarm));

    alarmController #(.toneHalfPeriod(toneHalfPeriod)) u_alarmController (
        .clk(clk), .reset(reset), .secondTick(secondTick),
        .alarmEnable(switches.alarmEnable),
        .currentTime(currentTime), .savedAlarm(savedAlarm),
        .alarmLed(alarmLed), .alarmActive(alarmActive), .beep(beep));

    // Reads the live switches directly for the alarm view
    displayScanner u_displayScanner (
        .clk(clk), .reset(reset), .refreshTick(refreshTick),
        .showAlarm(switches.showAlarm), .liveDigit(switches.liveDigit),
        .digitValue(switches.digitValue),
        .currentTime(currentTime), .savedAlarm(savedAlarm),
        .display(display));

endmodule

`default_nettype wire

// File: bench/alarmClockChecker.sv
`timescale 1ns/1ps
`default_nettype none

module alarmClockChecker #(
    parameter int clksPerSecond  = 16,
    parameter int clksPerRefresh = 2,
    parameter int toneHalfPeriod = 3
) (
    input  logic                     clk,
    input  logic                     reset,
    input  alarmClockPkg::switches_t switches,
    input  alarmClockPkg::segDrive_t display,
    input  logic                     alarmLed,
    input  logic                     alarmActive,
    input  logic                     beep,
    output int                       errorCount
);

    int secCount;
    int refreshCount;
    logic secTick;
    logic refreshTick;
    int seconds;                           // Time of day in plain seconds
    logic [3:0] savePrev;
    alarmClockPkg::bcdDigit_t saved [4];   // Index 0 is secOnes
    logic ledExp;
    logic activeExp;
    logic beepExp;
    int windowTicks;                       // Ticks counted inside the window
    int toneCount;
    int scanPos;
    alarmClockPkg::segDrive_t displayExp;
    logic alarmDue;
    logic windowEnds;
    logic started = 1'b0;
    int mismatches = 0;

    assign errorCount = mismatches;

    // Digit idx of a seconds count with idx 0 as secOnes
    function automatic alarmClockPkg::bcdDigit_t timeDigit(int secs, int idx);
        case (idx)
            0: return 4'(secs % 10);
            1: return 4'((secs % 60) / 10);
            2: return 4'((secs / 60) % 10);
            default: return 4'(secs / 600);
        endcase
    endfunction

    // What the display should hold once position p is shown
    function automatic alarmClockPkg::segDrive_t expectedDrive(int p);
        alarmClockPkg::segDrive_t drive;
        alarmClockPkg::bcdDigit_t d;
        if (!switches.showAlarm) begin
            d = timeDigit(seconds, p);
        end else if (switches.liveDigit[p]) begin
            d = switches.digitValue;  // Live dial value
        end else begin
            d = saved[p];
        end
        drive.segments = alarmClockPkg::SEG_PATTERNS[(d > 9) ? 0 : d];
        drive.anodes = 8'hFF;
        drive.anodes[p + (switches.showAlarm ? 4 : 0)] = 1'b0;  // Alarm on upper four
        drive.dp = (p != 2);
        return drive;
    endfunction

    always_comb begin
        alarmDue = switches.alarmEnable;
        for (int i = 0; i < 4; i++) begin
            if (timeDigit(seconds, i) != saved[i]) begin
                alarmDue = 1'b0;
            end
        end
    end

    assign windowEnds = secTick && activeExp &&
                        (windowTicks + 1 == alarmClockPkg::ALARM_SECONDS);

    always @(posedge clk) begin
        started <= 1'b1;
        if (!reset) begin
            secCount     <= 0;
            refreshCount <= 0;
            secTick      <= 1'b0;
            refreshTick  <= 1'b0;
            seconds      <= 0;
            savePrev     <= '0;
            saved        <= '{default: '0};
            ledExp       <= 1'b0;
            activeExp    <= 1'b0;
            beepExp      <= 1'b0;
            windowTicks  <= 0;
            toneCount    <= 0;
            scanPos      <= 3;     // First refresh shows position 0
            displayExp   <= '1;    // Blank
        end else begin
            secTick      <= (secCount == clksPerSecond - 1);
            secCount     <= (secCount == clksPerSecond - 1) ? 0 : secCount + 1;
            refreshTick  <= (refreshCount == clksPerRefresh - 1);
            refreshCount <= (refreshCount == clksPerRefresh - 1) ? 0 : refreshCount + 1;

            if (!switches.clockRun) begin
                seconds <= 0;
            end else if (secTick) begin
                seconds <= (seconds + 1) % 3600;  // 59:59 back to 00:00
            end

            savePrev <= switches.saveDigit;
            for (int i = 0; i < 4; i++) begin
                if (switches.saveDigit[i] && !savePrev[i]) begin
                    saved[i] <= switches.digitValue;
                end
            end

            ledExp <= switches.alarmEnable;

            if (windowEnds) begin
                activeExp   <= 1'b0;
                windowTicks <= 0;
            end else if (secTick && activeExp) begin
                windowTicks <= windowTicks + 1;
            end else if (secTick && alarmDue) begin
                activeExp   <= 1'b1;  // Opening tick is the first of ten
                windowTicks <= 1;
            end

            if (!activeExp || windowEnds) begin
                toneCount <= 0;
                beepExp   <= 1'b0;
            end else if (toneCount == toneHalfPeriod - 1) begin
                toneCount <= 0;
                beepExp   <= ~beepExp;
            end else begin
                toneCount <= toneCount + 1;
            end

            if (refreshTick) begin
                scanPos    <= (scanPos + 1) % alarmClockPkg::DIGIT_COUNT;
                displayExp <= expectedDrive((scanPos + 1) % alarmClockPkg::DIGIT_COUNT);
            end
        end
    end

    task automatic reportMismatch(string what, logic [15:0] got, logic [15:0] want);
        $display("mismatch at %0d ns: %s is %h, model expects %h", $time, what, got, want);
        mismatches++;
    endtask

    // Half a cycle after the edge where both sides have settled
    always @(negedge clk) begin
        if (started) begin
            if (display !== displayExp) begin
                reportMismatch("display", display, displayExp);
            end
            if (alarmLed !== ledExp) begin
                reportMismatch("alarmLed", 16'(alarmLed), 16'(ledExp));
            end
            if (alarmActive !== activeExp) begin
                reportMismatch("alarmActive", 16'(alarmActive), 16'(activeExp));
            end
            if (beep !== beepExp) begin
                reportMismatch("beep", 16'(beep), 16'(beepExp));
            end
        end
    end

endmodule

`default_nettype wire

// File: bench/alarmClockTb.sv
`timescale 1ns/1ps
`default_nettype none

module alarmClockTb;

    localparam int CLK_PERIOD       = 40;
    localparam int CLKS_PER_SECOND  = 16;
    localparam int CLKS_PER_REFRESH = 2;
    localparam int TONE_HALF_PERIOD = 3;
    localparam int WAIT_SECONDS     = 64;  // Longest wait for a window to open
    localparam int WINDOW_CYCLES    = (alarmClockPkg::ALARM_SECONDS - 1) * CLKS_PER_SECOND;

    // Worst case cycle budget of each phase
    localparam int PHASE1_CYCLES   = 3602 * CLKS_PER_SECOND;
    localparam int PHASE2_CYCLES   = 256 + 40 + 100;
    localparam int PHASE3_CYCLES   = 12 * 20;
    localparam int PHASE4_CYCLES   = 20 + (WAIT_SECONDS + alarmClockPkg::ALARM_SECONDS + 4)
                                     * CLKS_PER_SECOND;
    localparam int PHASE5_CYCLES   = 20 + WAIT_SECONDS * CLKS_PER_SECOND;
    localparam int WATCHDOG_CYCLES = 4 + PHASE1_CYCLES + PHASE2_CYCLES + PHASE3_CYCLES
                                     + PHASE4_CYCLES + PHASE5_CYCLES + 500;

    logic clk = 1'b0;
    logic reset;
    alarmClockPkg::switches_t switches;
    alarmClockPkg::segDrive_t display;
    logic alarmLed;
    logic alarmActive;
    logic beep;

    int seed;
    int checkErrors;
    int benchErrors;
    int errorsBefore;
    int phasesRun;
    int phasesFailed;
    int pause;
    int alarmSec;     // Alarm set to 00:alarmSec
    int waited;
    int activeCycles;
    int beepEdges;
    logic lastBeep;
    logic raised;

    always #(CLK_PERIOD / 2) clk = ~clk;

    alarmClockTop #(
        .clksPerSecond(CLKS_PER_SECOND),
        .clksPerRefresh(CLKS_PER_REFRESH),
        .toneHalfPeriod(TONE_HALF_PERIOD)
    ) u_alarmClockTop (
        .clk(clk), .reset(reset), .switches(switches), .display(display),
        .alarmLed(alarmLed), .alarmActive(alarmActive), .beep(beep));

    alarmClockChecker #(
        .clksPerSecond(CLKS_PER_SECOND),
        .clksPerRefresh(CLKS_PER_REFRESH),
        .toneHalfPeriod(TONE_HALF_PERIOD)
    ) u_alarmClockChecker (
        .clk(clk), .reset(reset), .switches(switches), .display(display),
        .alarmLed(alarmLed), .alarmActive(alarmActive), .beep(beep),
        .errorCount(checkErrors));

    // Inputs change 2 ns after the edge
    task automatic nextCycle();
        @(posedge clk);
        #2;
    endtask

    task automatic waitCycles(int n);
        repeat (n) nextCycle();
    endtask

    task automatic saveAlarmDigit(int idx, int value);
        switches.digitValue = 4'(value);
        switches.saveDigit  = 4'(1 << idx);
        nextCycle();
        switches.saveDigit = '0;
        nextCycle();
    endtask

    task automatic benchMismatch(string msg);
        $display("mismatch at %0d ns: %s", $time, msg);
        benchErrors++;
    endtask

    task automatic benchFailure(string msg);
        $display("error at %0d ns: %s", $time, msg);
        benchErrors++;
    endtask

    task automatic finishPhase(string name);
        int errs;
        errs = checkErrors + benchErrors - errorsBefore;
        phasesRun++;
        if (errs == 0) begin
            $display("phase %0d, %s: passed", phasesRun, name);
        end else begin
            phasesFailed++;
            $display("phase %0d, %s: failed with %0d errors", phasesRun, name, errs);
        end
        errorsBefore = checkErrors + benchErrors;
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: run still going after %0d cycles", WATCHDOG_CYCLES);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        seed         = 97;
        reset        = 1'b0;
        switches     = '0;
        benchErrors  = 0;
        errorsBefore = 0;
        phasesRun    = 0;
        phasesFailed = 0;
        repeat (4) @(posedge clk);
        #2;
        reset = 1'b1;

        // Full hour plus the wrap in the time view
        switches.clockRun   = 1'b1;
        switches.liveDigit  = 4'($random(seed));
        switches.digitValue = 4'($random(seed));
        waitCycles(PHASE1_CYCLES);
        finishPhase("timekeeping and wrap");

        pause = $random(seed) & 255;
        waitCycles(pause);
        switches.clockRun = 1'b0;
        waitCycles(40);
        switches.clockRun = 1'b1;
        waitCycles(100);
        finishPhase("run switch clears");

        for (int round = 0; round < 12; round++) begin
            switches.digitValue = 4'($random(seed));
            switches.saveDigit  = 4'($random(seed));  // Often several digits at once
            waitCycles(2);
            switches.saveDigit  = '0;
            switches.liveDigit  = 4'($random(seed));
            switches.digitValue = 4'($random(seed));  // May exceed 9
            switches.showAlarm  = (round % 4 != 3);
            waitCycles(16);
        end
        finishPhase("alarm setting and view");

        switches.showAlarm = 1'b0;
        switches.liveDigit = '0;
        switches.clockRun  = 1'b0;  // Park at 00:00 while dialing in
        alarmSec = 5 + ($random(seed) & 31);
        saveAlarmDigit(3, 0);
        saveAlarmDigit(2, 0);
        saveAlarmDigit(1, alarmSec / 10);
        saveAlarmDigit(0, alarmSec % 10);
        switches.alarmEnable = 1'b1;
        if (alarmLed !== 1'b0) begin
            benchMismatch("alarmLed high before the enable was sampled");
        end
        nextCycle();
        if (alarmLed !== 1'b1) begin
            benchMismatch("alarmLed not high one cycle after enable");
        end
        switches.clockRun = 1'b1;
        waited = 0;
        while (!alarmActive && waited < WAIT_SECONDS * CLKS_PER_SECOND) begin
            nextCycle();
            waited++;
        end
        if (!alarmActive) begin
            benchFailure("alarm window never opened");
        end else begin
            if (beep !== 1'b0) begin
                benchMismatch("beep not low at the start of the window");
            end
            activeCycles = 0;
            beepEdges    = 0;
            lastBeep     = beep;
            while (alarmActive && activeCycles < WINDOW_CYCLES + 2 * CLKS_PER_SECOND) begin
                nextCycle();
                activeCycles++;
                if (beep !== lastBeep) begin
                    beepEdges++;
                end
                lastBeep = beep;
            end
            // Opening tick comes just before the rise and nine more fall inside
            if (activeCycles != WINDOW_CYCLES) begin
                $display("mismatch at %0d ns: window lasted %0d cycles, expected %0d",
                         $time, activeCycles, WINDOW_CYCLES);
                benchErrors++;
            end
            if (beepEdges == 0) begin
                benchFailure("beep never toggled inside the alarm window");
            end
        end
        waitCycles(2 * CLKS_PER_SECOND);
        finishPhase("alarm window and beep");

        // Same alarm time with the alarm switched off
        switches.alarmEnable = 1'b0;
        switches.clockRun    = 1'b0;
        waitCycles(4);
        switches.clockRun = 1'b1;
        raised = 1'b0;
        repeat ((alarmSec + 5) * CLKS_PER_SECOND) begin
            nextCycle();
            if (alarmActive || beep) begin
                raised = 1'b1;
            end
        end
        if (raised) begin
            benchFailure("alarm went off while the alarm was disabled");
        end
        finishPhase("disabled alarm stays quiet");

        $display("summary: %0d phases run, %0d failed, %0d errors", phasesRun, phasesFailed,
                 checkErrors + benchErrors);
        if (checkErrors + benchErrors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
rtl/alarmClockPkg.sv
rtl/tickGenerator.sv
rtl/timeCounter.sv
rtl/alarmSetter.sv
rtl/alarmController.sv
rtl/displayScanner.sv
rtl/alarmClockTop.sv
bench/alarmClockChecker.sv
bench/alarmClockTb.sv

// File: run.sh
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f all.f \
    --top-module alarmClockTb --Mdir obj_dir -o simv > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "build failed, see build.log"
    exit 1
fi

./obj_dir/simv > sim.log 2>&1
if [ $? -ne 0 ]; then
    echo "simulation exited with an error, see sim.log"
    exit 1
fi

if grep -q "FAIL: see errors above" sim.log; then
    echo "simulation failed, see sim.log"
    exit 1
fi
echo "simulation passed"
exit 0
